// File: common/mips_pkg.sv
package mips_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [WORD_W-1:0] RESET_PC = 32'h0000_0000;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_COP0    = 6'h10;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // SPECIAL function codes, instr[5:0]
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // COP0 rs field
    localparam logic [4:0] COP0_MF = 5'h00;
    localparam logic [4:0] COP0_MT = 5'h04;

    // CP0 register numbers
    localparam logic [4:0] CP0_COUNT   = 5'd9;
    localparam logic [4:0] CP0_COMPARE = 5'd11;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } state_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        LUI
    } alu_op_e;

endpackage

// File: control/mips_control.sv
`timescale 1ns/1ns

module mips_control (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic [mips_pkg::WORD_W-1:0]     inst_sram_rdata_i,
    input  logic [mips_pkg::WORD_W-1:0]     data_sram_rdata_i,
    input  logic [mips_pkg::WORD_W-1:0]     alu_result_i,
    input  logic                            alu_equal_i,
    input  logic [mips_pkg::WORD_W-1:0]     rt_data_i,
    input  logic [mips_pkg::WORD_W-1:0]     cp0_rdata_i,
    input  logic                            reg_write_i,
    input  logic                            mem_read_i,
    input  logic                            mem_write_i,
    input  logic                            branch_i,
    input  logic                            cp0_read_i,
    input  logic                            cp0_write_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] dest_i,
    input  logic [mips_pkg::WORD_W-1:0]     imm_i,
    output logic [mips_pkg::WORD_W-1:0]     instr_o,
    output logic [mips_pkg::WORD_W-1:0]     pc_o,
    output logic [mips_pkg::WORD_W-1:0]     inst_sram_addr_o,
    output logic [mips_pkg::WORD_W-1:0]     data_sram_addr_o,
    output logic [3:0]                      data_sram_wen_o,
    output logic [mips_pkg::WORD_W-1:0]     data_sram_wdata_o,
    output logic                            cp0_we_o,
    output logic                            rf_we_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] rf_waddr_o,
    output logic [mips_pkg::WORD_W-1:0]     rf_wdata_o
);

    mips_pkg::state_e                state;
    logic [mips_pkg::WORD_W-1:0]     pc;
    logic [mips_pkg::WORD_W-1:0]     instr_q;
    logic [mips_pkg::WORD_W-1:0]     result_q;
    logic [mips_pkg::WORD_W-1:0]     next_pc;
    logic                            in_wb;

    assign in_wb = (state == mips_pkg::WRITEBACK);

    // no delay slot, target is relative to pc+4
    assign next_pc = (branch_i && alu_equal_i) ? pc + 32'd4 + imm_i : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= mips_pkg::FETCH;
            pc    <= mips_pkg::RESET_PC;
        end else begin
            case (state)
                mips_pkg::FETCH:   state <= mips_pkg::DECODE;
                mips_pkg::DECODE:  state <= mips_pkg::EXECUTE;
                mips_pkg::EXECUTE: begin
                    state <= (mem_read_i || mem_write_i) ? mips_pkg::MEMORY : mips_pkg::WRITEBACK;
                end
                mips_pkg::MEMORY:  state <= mips_pkg::WRITEBACK;
                mips_pkg::WRITEBACK: begin
                    state <= mips_pkg::FETCH;
                    pc    <= next_pc;
                end
                default:           state <= mips_pkg::FETCH;
            endcase
        end
    end

    // ir and result register
    always_ff @(posedge clk) begin
        if (state == mips_pkg::FETCH) begin
            instr_q <= inst_sram_rdata_i;
        end
        if (state == mips_pkg::EXECUTE) begin
            result_q <= cp0_read_i ? cp0_rdata_i : alu_result_i;
        end
        if (state == mips_pkg::MEMORY && mem_read_i) begin
            result_q <= data_sram_rdata_i;
        end
    end

    assign instr_o           = instr_q;
    assign pc_o              = pc;
    assign inst_sram_addr_o  = pc;
    assign data_sram_addr_o  = result_q;
    assign data_sram_wdata_o = rt_data_i;
    assign data_sram_wen_o   = (state == mips_pkg::MEMORY && mem_write_i) ? 4'hf : 4'h0;
    assign cp0_we_o          = in_wb && cp0_write_i;
    assign rf_we_o           = in_wb && reg_write_i;
    assign rf_waddr_o        = dest_i;
    assign rf_wdata_o        = result_q;

endmodule

// File: cp0/cp0_timer.sv
`timescale 1ns/1ns

module cp0_timer (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            we_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] addr_i,
    input  logic [mips_pkg::WORD_W-1:0]     wdata_i,
    output logic [mips_pkg::WORD_W-1:0]     rdata_o,
    output logic                            time_int_o
);

    logic [mips_pkg::WORD_W-1:0] count;
    logic [mips_pkg::WORD_W-1:0] compare;
    logic                        count_we;
    logic                        compare_we;

    assign count_we   = we_i && (addr_i == mips_pkg::CP0_COUNT);
    assign compare_we = we_i && (addr_i == mips_pkg::CP0_COMPARE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count      <= '0;
            compare    <= '1;
            time_int_o <= 1'b0;
        end else begin
            count <= count_we ? wdata_i : count + 32'd1;
            if (compare_we) begin
                compare    <= wdata_i;
                // writing compare acknowledges the timer
                time_int_o <= 1'b0;
            end else if (count == compare) begin
                time_int_o <= 1'b1;
            end
        end
    end

    always_comb begin
        case (addr_i)
            mips_pkg::CP0_COUNT:   rdata_o = count;
            mips_pkg::CP0_COMPARE: rdata_o = compare;
            default:               rdata_o = '0;
        endcase
    end

endmodule

// File: tb.f
+incdir+test
common/mips_pkg.sv
verilog/mips_alu.sv
verilog/mips_regfile.sv
verilog/mips_decoder.sv
cp0/cp0_timer.sv
control/mips_control.sv
verilog/mips_top.sv
test/tb_mips_top.sv

// File: test/tb_mips_model.svh
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

// reference state, one instruction at a time in program order
logic [31:0] m_regs [32];
logic [31:0] m_mem [64];
logic [31:0] exp_wb_pc [$];
logic [4:0]  exp_wb_num [$];
logic [31:0] exp_wb_data [$];
logic        exp_wb_int [$];
logic [31:0] exp_st_addr [$];
logic [31:0] exp_st_data [$];
int          exp_end_cycle;

// walks the program to the final self-branch and queues the expected events
task automatic run_model();
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] cmp;
    logic [31:0] next_pc;
    logic [4:0]  dst;
    logic        wr;
    int          cyc;
    int          cost;
    int          wb;
    int          last_mt;
    for (int i = 0; i < 32; i++) begin
        m_regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        m_mem[i] = data_fill(i);
    end
    pc = '0;
    cyc = 0;
    cmp = '1;
    last_mt = -1;
    while (pc != END_PC) begin
        ins     = imem[pc[8:2]];
        a       = m_regs[ins[25:21]];
        b       = m_regs[ins[20:16]];
        simm    = {{16{ins[15]}}, ins[15:0]};
        addr    = a + simm;
        dst     = ins[20:16];
        res     = '0;
        wr      = 1'b1;
        cost    = 4;
        next_pc = pc + 32'd4;
        case (ins[31:26])
            mips_pkg::OP_SPECIAL: begin
                dst = ins[15:11];
                case (ins[5:0])
                    mips_pkg::FN_ADDU: res = a + b;
                    mips_pkg::FN_SUBU: res = a - b;
                    mips_pkg::FN_AND:  res = a & b;
                    mips_pkg::FN_OR:   res = a | b;
                    mips_pkg::FN_XOR:  res = a ^ b;
                    mips_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:           wr = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: res = a + simm;
            mips_pkg::OP_ORI:   res = a | {16'h0000, ins[15:0]};
            mips_pkg::OP_LUI:   res = {ins[15:0], 16'h0000};
            mips_pkg::OP_LW: begin
                res  = m_mem[addr[7:2]];
                cost = 5;
            end
            mips_pkg::OP_SW: begin
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(b);
                m_mem[addr[7:2]] = b;
                wr   = 1'b0;
                cost = 5;
            end
            mips_pkg::OP_BEQ: begin
                wr = 1'b0;
                if (a == b) begin
                    next_pc = pc + 32'd4 + {simm[29:0], 2'b00};
                end
            end
            mips_pkg::OP_COP0: begin
                // count seen by MFC0 is the one of its third cycle
                if (ins[25:21] == mips_pkg::COP0_MF) begin
                    if (ins[15:11] == mips_pkg::CP0_COUNT) begin
                        res = 32'(cyc + 2);
                    end else if (ins[15:11] == mips_pkg::CP0_COMPARE) begin
                        res = cmp;
                    end
                end else begin
                    wr = 1'b0;
                    if (ins[25:21] == mips_pkg::COP0_MT && ins[15:11] == mips_pkg::CP0_COMPARE) begin
                        cmp = b;
                        last_mt = cyc + 3;
                    end
                end
            end
            default: wr = 1'b0;
        endcase
        wb = cyc + cost - 1;
        if (wr) begin
            exp_wb_pc.push_back(pc);
            exp_wb_num.push_back(dst);
            exp_wb_data.push_back(res);
            // match must fall after the compare write and before this writeback
            exp_wb_int.push_back(last_mt >= 0 && cmp > last_mt && cmp < wb);
            if (dst != 5'd0) begin
                m_regs[dst] = res;
            end
        end
        pc = next_pc;
        cyc += cost;
    end
    exp_end_cycle = cyc;
endtask

`endif

// File: test/tb_mips_top.sv
`timescale 1ns/1ns

module tb_mips_top;

    localparam int PROG_LEN    = 62;
    localparam int END_IDX     = PROG_LEN - 1;
    localparam int END_PC      = END_IDX * 4;
    localparam int CYCLE_LIMIT = 5 * PROG_LEN + 200;
    localparam logic [4:0] BASE_REG  = 5'd29;
    localparam logic [4:0] TIMER_REG = 5'd30;

    logic        clk = 1'b0;
    logic        reset_i;
    logic [31:0] inst_sram_addr_o;
    logic [31:0] inst_sram_rdata_i;
    logic [31:0] data_sram_addr_o;
    logic [3:0]  data_sram_wen_o;
    logic [31:0] data_sram_wdata_o;
    logic [31:0] data_sram_rdata_i;
    logic [31:0] debug_wb_pc_o;
    logic [3:0]  debug_wb_wen_o;
    logic [4:0]  debug_wb_num_o;
    logic [31:0] debug_wb_data_o;
    logic        time_int_o;

    logic [31:0] imem [128];
    logic [31:0] dmem [64];
    logic [31:0] rng = 32'd74070;
    int          cycle;

    always #20 clk = ~clk;

    mips_top i_dut (.*);

    // both memories answer in the same cycle
    assign inst_sram_rdata_i = imem[inst_sram_addr_o[8:2]];
    assign data_sram_rdata_i = dmem[data_sram_addr_o[7:2]];

    always @(posedge clk) begin
        if (data_sram_wen_o == 4'hf) begin
            dmem[data_sram_addr_o[7:2]] <= data_sram_wdata_o;
        end
    end

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] data_fill(int idx);
        return 32'h8c10_0000 + idx * 32'h0001_0203;
    endfunction

    `include "tb_mips_model.svh"

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("mismatch %s: expected %h actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic build_program();
        logic [5:0]  fn_list [6];
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        int          n;
        int          est;
        int          kind;
        int          off;
        fn_list = '{mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_AND,
                    mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_SLT};
        for (int i = 0; i < 128; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = data_fill(i);
        end
        // base of the 64-word load/store window
        imem[0] = {mips_pkg::OP_ORI, 5'd0, BASE_REG, 16'h0100};
        est = 4;
        n = 1;
        while (n < END_IDX) begin
            r  = next_random();
            r2 = next_random();
            rs = r[10:8];
            rt = r[13:11];
            rd = r[16:14];
            kind = r[31:20] % 14;
            if (kind == 13 && n + 2 > END_IDX) begin
                kind = 0;
            end
            case (kind)
                0, 1, 2, 3, 4, 5: imem[n] = {mips_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn_list[kind]};
                6:  imem[n] = {mips_pkg::OP_ADDIU, rs, rt, r2[15:0]};
                7:  imem[n] = {mips_pkg::OP_ORI, rs, rt, r2[15:0]};
                8:  imem[n] = {mips_pkg::OP_LUI, 5'd0, rt, r2[15:0]};
                9:  imem[n] = {mips_pkg::OP_LW, BASE_REG, rt, 8'h00, r2[5:0], 2'b00};
                10: imem[n] = {mips_pkg::OP_SW, BASE_REG, rt, 8'h00, r2[5:0], 2'b00};
                11: begin
                    off = 1 + r2[1:0];
                    if (off > END_IDX - n - 1) begin
                        off = END_IDX - n - 1;
                    end
                    imem[n] = {mips_pkg::OP_BEQ, rs, r2[2] ? rs : rt, 16'(off)};
                end
                12: begin
                    rd = r2[0] ? mips_pkg::CP0_COUNT : mips_pkg::CP0_COMPARE;
                    imem[n] = {mips_pkg::OP_COP0, mips_pkg::COP0_MF, rt, rd, 11'd0};
                end
                default: begin
                    // compare a little past the count reached without taken branches
                    imem[n] = {mips_pkg::OP_ORI, 5'd0, TIMER_REG, 16'(est + 8 + r2[4:0])};
                    imem[n + 1] = {mips_pkg::OP_COP0, mips_pkg::COP0_MT, TIMER_REG,
                                   mips_pkg::CP0_COMPARE, 11'd0};
                    n++;
                    est += 4;
                end
            endcase
            est += (kind == 9 || kind == 10) ? 5 : 4;
            n++;
        end
        imem[END_IDX] = {mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'hffff};
    endtask

    task automatic check_cycle();
        if (debug_wb_wen_o != 4'h0) begin
            assert (exp_wb_pc.size() > 0) else begin
                $display("register write at pc %h that the model does not expect", debug_wb_pc_o);
                stop_run();
            end
            compare_value("writeback strobes", 32'hf, 32'(debug_wb_wen_o));
            compare_value("writeback pc", exp_wb_pc.pop_front(), debug_wb_pc_o);
            compare_value("writeback register", 32'(exp_wb_num.pop_front()), 32'(debug_wb_num_o));
            compare_value("writeback data", exp_wb_data.pop_front(), debug_wb_data_o);
            compare_value("timer interrupt", 32'(exp_wb_int.pop_front()), 32'(time_int_o));
        end
        if (data_sram_wen_o != 4'h0) begin
            assert (exp_st_addr.size() > 0) else begin
                $display("data memory write to %h that the model does not expect", data_sram_addr_o);
                stop_run();
            end
            compare_value("store strobes", 32'hf, 32'(data_sram_wen_o));
            compare_value("store address", exp_st_addr.pop_front(), data_sram_addr_o);
            compare_value("store data", exp_st_data.pop_front(), data_sram_wdata_o);
        end
    endtask

    initial begin
        reset_i = 1'b1;
        build_program();
        run_model();
        repeat (16) @(negedge clk);
        reset_i = 1'b0;
        // cycle 0 is the first FETCH, count reads zero there
        cycle = 0;
        while (debug_wb_pc_o !== END_PC) begin
            check_cycle();
            @(negedge clk);
            cycle++;
            assert (cycle < CYCLE_LIMIT) else begin
                $display("timeout: final branch not reached within %0d cycles", CYCLE_LIMIT);
                stop_run();
            end
        end
        assert (exp_wb_pc.size() == 0 && exp_st_addr.size() == 0) else begin
            $display("program ended with %0d writebacks and %0d stores never seen",
                     exp_wb_pc.size(), exp_st_addr.size());
            stop_run();
        end
        compare_value("end cycle", 32'(exp_end_cycle), 32'(cycle));
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: verilog/mips_alu.sv
`timescale 1ns/1ns

module mips_alu (
    input  mips_pkg::alu_op_e           alu_op_i,
    input  logic [mips_pkg::WORD_W-1:0] a_i,
    input  logic [mips_pkg::WORD_W-1:0] b_i,
    output logic [mips_pkg::WORD_W-1:0] result_o,
    output logic                        equal_o
);

    always_comb begin
        result_o = '0;
        case (alu_op_i)
            mips_pkg::ADD: result_o = a_i + b_i;
            mips_pkg::SUB: result_o = a_i - b_i;
            mips_pkg::AND: result_o = a_i & b_i;
            mips_pkg::OR:  result_o = a_i | b_i;
            mips_pkg::XOR: result_o = a_i ^ b_i;
            mips_pkg::SLT: begin
                // signed compare
                result_o[0] = $signed(a_i) < $signed(b_i);
            end
            mips_pkg::LUI: result_o = b_i << 16;
            default:       result_o = '0;
        endcase
    end

    // beq condition
    assign equal_o = (a_i == b_i);

endmodule

// File: verilog/mips_decoder.sv
`timescale 1ns/1ns

module mips_decoder (
    input  logic [mips_pkg::WORD_W-1:0]     instr_i,
    output mips_pkg::alu_op_e               alu_op_o,
    output logic                            use_imm_o,
    output logic [mips_pkg::WORD_W-1:0]     imm_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] dest_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] rs_addr_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] rt_addr_o,
    output logic                            reg_write_o,
    output logic                            mem_read_o,
    output logic                            mem_write_o,
    output logic                            branch_o,
    output logic                            cp0_read_o,
    output logic                            cp0_write_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    logic [mips_pkg::WORD_W-1:0] sign_imm;
    logic [mips_pkg::WORD_W-1:0] zero_imm;

    assign opcode    = instr_i[31:26];
    assign funct     = instr_i[5:0];
    assign imm16     = instr_i[15:0];
    assign sign_imm  = {{16{imm16[15]}}, imm16};
    assign zero_imm  = {16'h0000, imm16};
    assign rs_addr_o = instr_i[25:21];
    assign rt_addr_o = instr_i[20:16];

    always_comb begin
        alu_op_o    = mips_pkg::ADD;
        use_imm_o   = 1'b0;
        imm_o       = sign_imm;
        dest_o      = instr_i[15:11];
        reg_write_o = 1'b0;
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        branch_o    = 1'b0;
        cp0_read_o  = 1'b0;
        cp0_write_o = 1'b0;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                reg_write_o = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op_o = mips_pkg::ADD;
                    mips_pkg::FN_SUBU: alu_op_o = mips_pkg::SUB;
                    mips_pkg::FN_AND:  alu_op_o = mips_pkg::AND;
                    mips_pkg::FN_OR:   alu_op_o = mips_pkg::OR;
                    mips_pkg::FN_XOR:  alu_op_o = mips_pkg::XOR;
                    mips_pkg::FN_SLT:  alu_op_o = mips_pkg::SLT;
                    default:           reg_write_o = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                use_imm_o   = 1'b1;
                dest_o      = instr_i[20:16];
                reg_write_o = 1'b1;
            end
            mips_pkg::OP_ORI, mips_pkg::OP_LUI: begin
                alu_op_o    = (opcode == mips_pkg::OP_ORI) ? mips_pkg::OR : mips_pkg::LUI;
                use_imm_o   = 1'b1;
                imm_o       = zero_imm;
                dest_o      = instr_i[20:16];
                reg_write_o = 1'b1;
            end
            mips_pkg::OP_LW: begin
                use_imm_o   = 1'b1;
                dest_o      = instr_i[20:16];
                reg_write_o = 1'b1;
                mem_read_o  = 1'b1;
            end
            mips_pkg::OP_SW: begin
                use_imm_o   = 1'b1;
                mem_write_o = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                // word offset, ready to add to pc+4
                alu_op_o = mips_pkg::SUB;
                imm_o    = {{14{imm16[15]}}, imm16, 2'b00};
                branch_o = 1'b1;
            end
            mips_pkg::OP_COP0: begin
                dest_o = instr_i[20:16];
                if (instr_i[25:21] == mips_pkg::COP0_MF) begin
                    cp0_read_o  = 1'b1;
                    reg_write_o = 1'b1;
                end else if (instr_i[25:21] == mips_pkg::COP0_MT) begin
                    cp0_write_o = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/mips_regfile.sv
`timescale 1ns/1ns

module mips_regfile (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rs_addr_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rt_addr_i,
    input  logic                            we_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [mips_pkg::WORD_W-1:0]     wdata_i,
    output logic [mips_pkg::WORD_W-1:0]     rs_data_o,
    output logic [mips_pkg::WORD_W-1:0]     rt_data_o
);

    logic [mips_pkg::WORD_W-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // $zero reads as zero regardless of array contents
    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

endmodule

// File: verilog/mips_top.sv
`timescale 1ns/1ns

module mips_top (
    input  logic                            clk,
    input  logic                            reset_i,

    output logic [mips_pkg::WORD_W-1:0]     inst_sram_addr_o,
    input  logic [mips_pkg::WORD_W-1:0]     inst_sram_rdata_i,

    output logic [mips_pkg::WORD_W-1:0]     data_sram_addr_o,
    output logic [3:0]                      data_sram_wen_o,
    output logic [mips_pkg::WORD_W-1:0]     data_sram_wdata_o,
    input  logic [mips_pkg::WORD_W-1:0]     data_sram_rdata_i,

    output logic [mips_pkg::WORD_W-1:0]     debug_wb_pc_o,
    output logic [3:0]                      debug_wb_wen_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] debug_wb_num_o,
    output logic [mips_pkg::WORD_W-1:0]     debug_wb_data_o,

    output logic                            time_int_o
);

    logic [mips_pkg::WORD_W-1:0]     instr;
    logic [mips_pkg::WORD_W-1:0]     pc;
    mips_pkg::alu_op_e               alu_op;
    logic                            use_imm;
    logic [mips_pkg::WORD_W-1:0]     imm;
    logic [mips_pkg::REG_ADDR_W-1:0] dest;
    logic [mips_pkg::REG_ADDR_W-1:0] rs_addr;
    logic [mips_pkg::REG_ADDR_W-1:0] rt_addr;
    logic                            reg_write;
    logic                            mem_read;
    logic                            mem_write;
    logic                            branch;
    logic                            cp0_read;
    logic                            cp0_write;
    logic [mips_pkg::WORD_W-1:0]     rs_data;
    logic [mips_pkg::WORD_W-1:0]     rt_data;
    logic [mips_pkg::WORD_W-1:0]     alu_b;
    logic [mips_pkg::WORD_W-1:0]     alu_result;
    logic                            alu_equal;
    logic [mips_pkg::WORD_W-1:0]     cp0_rdata;
    logic                            cp0_we;
    logic                            rf_we;
    logic [mips_pkg::REG_ADDR_W-1:0] rf_waddr;
    logic [mips_pkg::WORD_W-1:0]     rf_wdata;

    assign alu_b = use_imm ? imm : rt_data;

    // debug port mirrors the register file write
    assign debug_wb_pc_o   = pc;
    assign debug_wb_wen_o  = {4{rf_we}};
    assign debug_wb_num_o  = rf_waddr;
    assign debug_wb_data_o = rf_wdata;

    mips_control u_control (
        .clk               (clk),
        .reset_i           (reset_i),
        .inst_sram_rdata_i (inst_sram_rdata_i),
        .data_sram_rdata_i (data_sram_rdata_i),
        .alu_result_i      (alu_result),
        .alu_equal_i       (alu_equal),
        .rt_data_i         (rt_data),
        .cp0_rdata_i       (cp0_rdata),
        .reg_write_i       (reg_write),
        .mem_read_i        (mem_read),
        .mem_write_i       (mem_write),
        .branch_i          (branch),
        .cp0_read_i        (cp0_read),
        .cp0_write_i       (cp0_write),
        .dest_i            (dest),
        .imm_i             (imm),
        .instr_o           (instr),
        .pc_o              (pc),
        .inst_sram_addr_o  (inst_sram_addr_o),
        .data_sram_addr_o  (data_sram_addr_o),
        .data_sram_wen_o   (data_sram_wen_o),
        .data_sram_wdata_o (data_sram_wdata_o),
        .cp0_we_o          (cp0_we),
        .rf_we_o           (rf_we),
        .rf_waddr_o        (rf_waddr),
        .rf_wdata_o        (rf_wdata)
    );

    mips_decoder u_decoder (
        .instr_i     (instr),
        .alu_op_o    (alu_op),
        .use_imm_o   (use_imm),
        .imm_o       (imm),
        .dest_o      (dest),
        .rs_addr_o   (rs_addr),
        .rt_addr_o   (rt_addr),
        .reg_write_o (reg_write),
        .mem_read_o  (mem_read),
        .mem_write_o (mem_write),
        .branch_o    (branch),
        .cp0_read_o  (cp0_read),
        .cp0_write_o (cp0_write)
    );

    mips_regfile u_regfile (
        .clk       (clk),
        .reset_i   (reset_i),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data)
    );

    mips_alu u_alu (
        .alu_op_i (alu_op),
        .a_i      (rs_data),
        .b_i      (alu_b),
        .result_o (alu_result),
        .equal_o  (alu_equal)
    );

    // cp0 register number sits in the rd field
    cp0_timer u_cp0_timer (
        .clk        (clk),
        .reset_i    (reset_i),
        .we_i       (cp0_we),
        .addr_i     (instr[15:11]),
        .wdata_i    (rt_data),
        .rdata_o    (cp0_rdata),
        .time_int_o (time_int_o)
    );

endmodule
